// File: common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // datapath word width
  parameter int xlen = 32;

  // architectural register index width, 32 integer registers
  parameter int reg_w = 5;
  parameter int num_regs = 1 << reg_w;

  // exception record split of one completion word
  parameter int cause_w = 4;
  parameter int badaddr_w = xlen - cause_w;

  typedef logic [reg_w-1:0] reg_idx_t;

  // functional unit class of the instruction sitting in decode
  typedef enum logic [1:0] {
    ARITH_S     = 2'd0,
    MUL_S       = 2'd1,
    DIV_S       = 2'd2,
    LOADSTORE_S = 2'd3
  } fu_type_t;

  // operand select
  // 0 and 1 read the register file, 2 and 3 bypass it
  typedef enum logic [1:0] {
    SRC_REG0 = 2'd0,
    SRC_REG1 = 2'd1,
    SRC_PC   = 2'd2,
    SRC_IMM  = 2'd3
  } src_sel_t;

  // on a load/store, source a set to this value marks a store
  parameter src_sel_t store_mark = SRC_REG1;

  // exception view of a completion word
  typedef struct packed {
    logic [cause_w-1:0]   cause;
    logic [badaddr_w-1:0] badaddr;
  } exc_rec_t;

  // a finished entry carries either its result or its exception record
  // the entry's exc flag selects the view
  typedef union packed {
    logic [xlen-1:0] result;
    exc_rec_t        exc;
  } cb_word_u;

  // true when the select pulls the operand from a register
  function automatic logic reads_reg(input src_sel_t sel);
    return (sel == SRC_REG0) || (sel == SRC_REG1);
  endfunction

endpackage

`default_nettype wire

// File: hazard/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import ooo_pkg::*; (
  input  logic     dispatch_valid,
  input  fu_type_t fu_type,
  input  src_sel_t source_a_sel,
  input  src_sel_t source_b_sel,
  input  logic     wen,
  input  logic     rs1_busy,
  input  logic     rs2_busy,
  input  logic     rd_busy,
  input  logic     busy_du,
  input  logic     busy_ls,
  input  logic     busy_decode,
  input  logic     rob_full,
  input  logic     rob_empty,
  input  logic     exc_pending,
  output logic     dispatch_ready,
  output logic     dispatch_fire,
  output logic     stall_fetch_decode,
  output logic     pc_en,
  output logic     data_hazard,
  output logic     structural_hazard
);

  logic rs1_hit;
  logic rs2_hit;
  logic rd_hit;
  logic store;
  logic store_wait;

  // a busy source only matters when the operand comes from the register file
  // pc and immediate selects never wait
  assign rs1_hit = reads_reg(source_a_sel) & rs1_busy;
  assign rs2_hit = reads_reg(source_b_sel) & rs2_busy;

  // waw on the destination, only if this instruction writes back
  assign rd_hit = wen & rd_busy;

  assign data_hazard = rs1_hit | rs2_hit | rd_hit;

  // divider and load/store unit are not pipelined
  // arith and mul accept a new op every cycle
  assign structural_hazard = ((fu_type == DIV_S) & busy_du) |
                             ((fu_type == LOADSTORE_S) & busy_ls);

  // stores go out in program order with nothing older in flight
  assign store      = (fu_type == LOADSTORE_S) & (source_a_sel == store_mark);
  assign store_wait = store & ~rob_empty;

  // any of these holds the instruction in decode
  // rob_full: no free tag to hand out
  // exc_pending: younger work is about to be flushed anyway
  assign stall_fetch_decode = data_hazard |
                              structural_hazard |
                              store_wait |
                              busy_decode |
                              rob_full |
                              exc_pending;

  assign dispatch_ready = ~stall_fetch_decode;

  // single place where a dispatch is decided
  // scoreboard and buffer act on this strobe only
  assign dispatch_fire = dispatch_valid & dispatch_ready;

  // fetch advances only while decode can drain
  assign pc_en = ~stall_fetch_decode;

endmodule

`default_nettype wire

// File: hazard/reg_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module reg_scoreboard import ooo_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     wen,
  input  logic     dispatch_fire,
  input  logic     commit_valid,
  input  reg_idx_t commit_rd,
  input  logic     commit_wen,
  input  logic     flush,
  output logic     rs1_busy,
  output logic     rs2_busy,
  output logic     rd_busy
);

  // one flop per register, x0 has none
  logic [num_regs-1:1] busy_q;
  logic [num_regs-1:1] busy_d;
  logic [num_regs-1:0] busy_vec;

  // x0 reads back as never busy
  assign busy_vec = {busy_q, 1'b0};

  assign rs1_busy = busy_vec[rs1];
  assign rs2_busy = busy_vec[rs2];
  assign rd_busy  = busy_vec[rd];

  always_comb begin
    busy_d = busy_q;
    for (int i = 1; i < num_regs; i++) begin
      // commit releases the destination
      if (commit_valid && commit_wen && (commit_rd == reg_idx_t'(i))) begin
        busy_d[i] = 1'b0;
      end
      // a new writer in the same cycle keeps it busy
      if (dispatch_fire && wen && (rd == reg_idx_t'(i))) begin
        busy_d[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (flush) begin
      // everything in flight is discarded
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

endmodule

`default_nettype wire

// File: completion_buffer/completion_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module completion_buffer import ooo_pkg::*; #(
  parameter int cb_depth = 4,
  parameter int tag_w    = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dispatch_fire,
  input  reg_idx_t         rd,
  input  logic             wen,
  input  logic [xlen-1:0]  pc,
  input  logic             wb_valid,
  input  logic [tag_w-1:0] wb_tag,
  input  logic             wb_exc,
  input  cb_word_u         wb_word,
  input  logic             flush,
  output logic [tag_w-1:0] alloc_tag,
  output logic             rob_full,
  output logic             rob_empty,
  output logic             commit_valid,
  output reg_idx_t         commit_rd,
  output logic             commit_wen,
  output cb_word_u         commit_word,
  output logic [tag_w-1:0] commit_tag,
  output logic             head_exc,
  output cb_word_u         head_word,
  output logic [xlen-1:0]  head_pc
);

  localparam logic [tag_w:0] full_count = (tag_w+1)'(cb_depth);

  // entry payload, written at dispatch and writeback
  reg_idx_t        ent_rd   [cb_depth];
  logic [xlen-1:0] ent_pc   [cb_depth];
  cb_word_u        ent_word [cb_depth];
  logic [cb_depth-1:0] ent_wen;

  // entry status
  logic [cb_depth-1:0] ent_done;
  logic [cb_depth-1:0] ent_exc;

  // head is the oldest entry, tail the next free slot
  logic [tag_w-1:0] head_q;
  logic [tag_w-1:0] tail_q;
  logic [tag_w:0]   count_q;
  logic             head_done;

  assign rob_empty = (count_q == '0);
  assign rob_full  = (count_q == full_count);
  assign alloc_tag = tail_q;

  // head finished, either way
  assign head_done = ~rob_empty & ent_done[head_q];

  // clean result retires, faulting one parks at the head until flush
  assign commit_valid = head_done & ~ent_exc[head_q];
  assign head_exc     = head_done & ent_exc[head_q];

  assign commit_rd   = ent_rd[head_q];
  assign commit_wen  = ent_wen[head_q];
  assign commit_word = ent_word[head_q];
  assign commit_tag  = head_q;

  // exception reporter reads the same word through the exc view
  assign head_word = ent_word[head_q];
  assign head_pc   = ent_pc[head_q];

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      // pointer wrap is free for a power of two depth
      if (dispatch_fire) begin
        tail_q <= tail_q + 1'b1;
      end
      if (commit_valid) begin
        head_q <= head_q + 1'b1;
      end
      case ({dispatch_fire, commit_valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // done and exc flags per entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_done <= '0;
      ent_exc  <= '0;
    end else if (flush) begin
      ent_done <= '0;
      ent_exc  <= '0;
    end else begin
      // fresh entry starts not done
      if (dispatch_fire) begin
        ent_done[tail_q] <= 1'b0;
        ent_exc[tail_q]  <= 1'b0;
      end
      // writeback may land on any in-flight tag, any order
      if (wb_valid) begin
        ent_done[wb_tag] <= 1'b1;
        ent_exc[wb_tag]  <= wb_exc;
      end
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (dispatch_fire) begin
      ent_rd[tail_q]  <= rd;
      ent_wen[tail_q] <= wen;
      ent_pc[tail_q]  <= pc;
    end
    if (wb_valid) begin
      ent_word[wb_tag] <= wb_word;
    end
  end

endmodule

`default_nettype wire

// File: design/exception_reporter.sv
`timescale 1ns/1ns
`default_nettype none

module exception_reporter import ooo_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 head_exc,
  input  cb_word_u             head_word,
  input  logic [xlen-1:0]      head_pc,
  input  logic                 exc_ack,
  output logic                 exc_req,
  output logic [cause_w-1:0]   exc_cause,
  output logic [badaddr_w-1:0] exc_badaddr,
  output logic [xlen-1:0]      exc_epc,
  output logic                 exc_pending,
  output logic                 flush
);

  // fsm states
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_req   = 2'd1;
  localparam logic [1:0] st_wrel  = 2'd2;
  localparam logic [1:0] st_flush = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // faulting head seen, raise req next cycle
      st_idle:  if (head_exc) state_d = st_req;
      // hold req until privilege block acks
      st_req:   if (exc_ack) state_d = st_wrel;
      // req is down, wait for ack to drop
      st_wrel:  if (!exc_ack) state_d = st_flush;
      // one cycle of flush then back to idle
      default:  state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // capture the record once, stays put through the whole handshake
  always_ff @(posedge clk) begin
    if ((state_q == st_idle) && head_exc) begin
      exc_cause   <= head_word.exc.cause;
      exc_badaddr <= head_word.exc.badaddr;
      exc_epc     <= head_pc;
    end
  end

  assign exc_req = (state_q == st_req);
  assign flush   = (state_q == st_flush);

  // blocks dispatch from the first sighting until the flush cycle ends
  assign exc_pending = head_exc | (state_q != st_idle);

endmodule

`default_nettype wire

// File: design/ooo_issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_issue_ctrl import ooo_pkg::*; #(
  parameter int cb_depth = 4,
  parameter int tag_w    = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // dispatch side
  input  logic                 dispatch_valid,
  input  fu_type_t             fu_type,
  input  src_sel_t             source_a_sel,
  input  src_sel_t             source_b_sel,
  input  reg_idx_t             rs1,
  input  reg_idx_t             rs2,
  input  reg_idx_t             rd,
  input  logic                 wen,
  input  logic [xlen-1:0]      pc,
  input  logic                 busy_du,
  input  logic                 busy_ls,
  input  logic                 busy_decode,
  output logic                 dispatch_ready,
  output logic                 dispatch_fire,
  output logic                 stall_fetch_decode,
  output logic                 pc_en,
  output logic                 data_hazard,
  output logic                 structural_hazard,
  output logic [tag_w-1:0]     alloc_tag,
  output logic                 rob_full,
  output logic                 rob_empty,
  // writeback side
  input  logic                 wb_valid,
  input  logic [tag_w-1:0]     wb_tag,
  input  logic                 wb_exc,
  input  cb_word_u             wb_word,
  // commit side
  output logic                 commit_valid,
  output reg_idx_t             commit_rd,
  output logic                 commit_wen,
  output cb_word_u             commit_word,
  output logic [tag_w-1:0]     commit_tag,
  // exception link to privilege block
  output logic                 exc_req,
  output logic [cause_w-1:0]   exc_cause,
  output logic [badaddr_w-1:0] exc_badaddr,
  output logic [xlen-1:0]      exc_epc,
  input  logic                 exc_ack,
  output logic                 flush
);

  // scoreboard to hazard unit
  logic rs1_busy;
  logic rs2_busy;
  logic rd_busy;

  // buffer head to exception reporter
  logic            head_exc;
  cb_word_u        head_word;
  logic [xlen-1:0] head_pc;
  logic            exc_pending;

  hazard_unit hazard_unit0 (.*);

  reg_scoreboard reg_scoreboard0 (.*);

  completion_buffer #(
    .cb_depth (cb_depth),
    .tag_w    (tag_w)
  ) completion_buffer0 (.*);

  exception_reporter exception_reporter0 (.*);

endmodule

`default_nettype wire

// File: tb/ooo_issue_ctrl_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_issue_ctrl_assertions (
  input logic clk,
  input logic rst_n,
  input logic dispatch_fire,
  input logic rob_full,
  input logic commit_valid,
  input logic head_exc,
  input logic exc_req,
  input logic exc_ack,
  input logic flush
);

  // four-phase link, req may only drop after ack
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    exc_req && !exc_ack |=> exc_req)
    else $error("exc_req dropped before exc_ack");

  // flush is a single-cycle pulse
  flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !flush)
    else $error("flush held longer than one cycle");

  // no tag handed out while the buffer is full
  no_fire_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(dispatch_fire && rob_full))
    else $error("dispatch fired into a full buffer");

  // a faulting head never retires
  commit_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(commit_valid && head_exc))
    else $error("commit and head exception at the same time");

endmodule

// buffer side checks, handshake inputs tied low
bind completion_buffer ooo_issue_ctrl_assertions cb_checks (
  .clk, .rst_n, .dispatch_fire, .rob_full, .commit_valid, .head_exc,
  .exc_req(1'b0), .exc_ack(1'b0), .flush
);

// reporter side checks, buffer inputs tied low
bind exception_reporter ooo_issue_ctrl_assertions er_checks (
  .clk, .rst_n, .dispatch_fire(1'b0), .rob_full(1'b0), .commit_valid(1'b0),
  .head_exc, .exc_req, .exc_ack, .flush
);

`default_nettype wire

// File: tb/tb_ooo_issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_issue_ctrl import ooo_pkg::*; ();

  localparam int cb_depth = 4;
  localparam int tag_w = 2;
  localparam int wait_limit = 40;
  // exception record used by the faulting writeback
  localparam logic [cause_w-1:0] exc_cause_c = 4'h5;
  localparam logic [badaddr_w-1:0] exc_badaddr_c = 28'h0abc_de1;

  logic clk;
  logic rst_n;
  logic dispatch_valid;
  fu_type_t fu_type;
  src_sel_t source_a_sel;
  src_sel_t source_b_sel;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic wen;
  logic [xlen-1:0] pc;
  logic busy_du;
  logic busy_ls;
  logic busy_decode;
  logic dispatch_ready;
  logic dispatch_fire;
  logic stall_fetch_decode;
  logic pc_en;
  logic data_hazard;
  logic structural_hazard;
  logic [tag_w-1:0] alloc_tag;
  logic rob_full;
  logic rob_empty;
  logic wb_valid;
  logic [tag_w-1:0] wb_tag;
  logic wb_exc;
  cb_word_u wb_word;
  logic commit_valid;
  reg_idx_t commit_rd;
  logic commit_wen;
  cb_word_u commit_word;
  logic [tag_w-1:0] commit_tag;
  logic exc_req;
  logic [cause_w-1:0] exc_cause;
  logic [badaddr_w-1:0] exc_badaddr;
  logic [xlen-1:0] exc_epc;
  logic exc_ack;
  logic flush;

  ooo_issue_ctrl #(.cb_depth(cb_depth), .tag_w(tag_w)) dut0 (.*);

  typedef enum {PROBE, DISP, WB, WBX, ACK, DRAIN} act_e;

  // one stimulus step, busy is {busy_du, busy_ls}
  // cmt[1] enables the commit check, cmt[0] is the expected commit_valid
  // haz is the expected {data_hazard, structural_hazard}
  typedef struct {
    string    name;
    act_e     act;
    fu_type_t fu;
    src_sel_t sa;
    src_sel_t sb;
    reg_idx_t rs;
    reg_idx_t rd;
    logic     wen;
    logic [1:0] busy;
    int       tag;
    logic     ready;
    logic [1:0] cmt;
    logic [1:0] haz;
  } step_t;

  step_t steps[$];
  // model of in-flight entries, indexed by tag
  logic [31:0] model_word [cb_depth];
  reg_idx_t model_rd [cb_depth];
  logic model_wen [cb_depth];
  logic [31:0] model_pc [cb_depth];
  logic [tag_w-1:0] order_q[$];
  // next tag the buffer should hand out
  int tail_model;
  logic [31:0] lfsr;
  int exc_tag;
  int errors;
  int step_no;
  string cur_name;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  function automatic void add(input string name, input act_e act, input fu_type_t fu,
                              input src_sel_t sa, input src_sel_t sb, input int rs,
                              input int rd_i, input logic wen_i, input logic [1:0] busy,
                              input int tag, input logic ready, input logic [1:0] cmt,
                              input logic [1:0] haz);
    step_t s;
    s.name = name;
    s.act = act;
    s.fu = fu;
    s.sa = sa;
    s.sb = sb;
    s.rs = reg_idx_t'(rs);
    s.rd = reg_idx_t'(rd_i);
    s.wen = wen_i;
    s.busy = busy;
    s.tag = tag;
    s.ready = ready;
    s.cmt = cmt;
    s.haz = haz;
    steps.push_back(s);
  endfunction

  // in-order commit monitor, one entry retires per cycle at most
  // occupancy flags follow the model before this cycle's commit is popped
  always @(negedge clk) begin
    if (rst_n) begin
      check(cur_name, 32'(order_q.size() == cb_depth), 32'(rob_full));
      check(cur_name, 32'(order_q.size() == 0), 32'(rob_empty));
      if (commit_valid) begin
        if (order_q.size() == 0) begin
          $display("%s: commit seen with no entry in flight", cur_name);
          errors++;
        end else begin
          check(cur_name, 32'(order_q[0]), 32'(commit_tag));
          check(cur_name, model_word[order_q[0]], commit_word.result);
          check(cur_name, 32'(model_rd[order_q[0]]), 32'(commit_rd));
          check(cur_name, 32'(model_wen[order_q[0]]), 32'(commit_wen));
          void'(order_q.pop_front());
        end
      end
    end
  end

  function automatic logic link_level(input int which);
    return (which == 0) ? exc_req : flush;
  endfunction

  // wait on exc_req (0) or flush (1) reaching a level
  task automatic wait_link(input string name, input int which, input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (link_level(which) !== level && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (link_level(which) !== level) begin
      $display("%s: timed out waiting for %s to go %0d", name,
               (which == 0) ? "exc_req" : "flush", level);
      errors++;
    end
  endtask

  task automatic run_ack(input string name);
    wait_link(name, 0, 1'b1);
    check(name, 32'(exc_cause_c), 32'(exc_cause));
    check(name, 32'(exc_badaddr_c), 32'(exc_badaddr));
    check(name, model_pc[exc_tag], exc_epc);
    @(posedge clk);
    exc_ack <= 1'b1;
    wait_link(name, 0, 1'b0);
    @(posedge clk);
    exc_ack <= 1'b0;
    wait_link(name, 1, 1'b1);
    // buffer and scoreboard clear on the flush edge
    @(posedge clk);
    order_q.delete();
    @(negedge clk);
    check(name, 32'd1, 32'(rob_empty));
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (order_q.size() != 0 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (order_q.size() != 0) begin
      $display("%s: timed out waiting for in-flight entries to commit", name);
      errors++;
    end
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] word;
    @(posedge clk);
    fu_type <= s.fu;
    source_a_sel <= s.sa;
    source_b_sel <= s.sb;
    rs1 <= s.rs;
    rs2 <= s.rs;
    rd <= s.rd;
    wen <= s.wen;
    busy_du <= s.busy[1];
    busy_ls <= s.busy[0];
    pc <= 32'h0000_1000 + 32'(step_no * 4);
    dispatch_valid <= (s.act == DISP);
    wb_valid <= (s.act == WB) || (s.act == WBX);
    wb_tag <= tag_w'(s.tag);
    wb_exc <= (s.act == WBX);
    if (s.act == WB) begin
      word = random_word();
      model_word[s.tag] = word;
      wb_word <= word;
    end else begin
      wb_word <= {exc_cause_c, exc_badaddr_c};
    end
    if (s.act == WBX) begin
      exc_tag = s.tag;
    end
    // hazard decision is combinational, sample before the edge
    @(negedge clk);
    check(s.name, 32'(s.ready), 32'(dispatch_ready));
    check(s.name, 32'(!s.ready), 32'(stall_fetch_decode));
    check(s.name, 32'(s.ready), 32'(pc_en));
    check(s.name, 32'((s.act == DISP) && s.ready), 32'(dispatch_fire));
    check(s.name, 32'(s.haz), 32'({data_hazard, structural_hazard}));
    if (s.act == DISP && s.ready) begin
      check(s.name, 32'(tail_model), 32'(alloc_tag));
    end
    @(posedge clk);
    dispatch_valid <= 1'b0;
    wb_valid <= 1'b0;
    // the new entry is in the buffer from this edge on
    if (s.act == DISP && s.ready) begin
      model_rd[tail_model] = s.rd;
      model_wen[tail_model] = s.wen;
      model_pc[tail_model] = pc;
      order_q.push_back(tag_w'(tail_model));
      tail_model = (tail_model + 1) % cb_depth;
    end
    if (s.act == ACK) begin
      run_ack(s.name);
    end else if (s.act == DRAIN) begin
      wait_drain(s.name);
    end else begin
      @(negedge clk);
      if (s.cmt[1]) begin
        check(s.name, 32'(s.cmt[0]), 32'(commit_valid));
      end
    end
  endtask

  initial begin
    int err_before;
    int failed;
    errors = 0;
    failed = 0;
    tail_model = 0;
    lfsr = 32'd69;
    cur_name = "reset";
    rst_n = 1'b0;
    dispatch_valid = 1'b0;
    fu_type = ARITH_S;
    source_a_sel = SRC_PC;
    source_b_sel = SRC_IMM;
    rs1 = '0;
    rs2 = '0;
    rd = '0;
    wen = 1'b0;
    pc = '0;
    busy_du = 1'b0;
    busy_ls = 1'b0;
    busy_decode = 1'b0;
    wb_valid = 1'b0;
    wb_tag = '0;
    wb_exc = 1'b0;
    wb_word = '0;
    exc_ack = 1'b0;

    // data hazards on x5
    add("w5_dispatch", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 5, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("raw_sel0", PROBE, ARITH_S, SRC_REG0, SRC_IMM, 5, 6, 1, 2'b00, 0, 0, 2'b00, 2'b10);
    add("raw_sel1", PROBE, ARITH_S, SRC_PC, SRC_REG1, 5, 6, 1, 2'b00, 0, 0, 2'b00, 2'b10);
    add("pc_sel2", PROBE, ARITH_S, SRC_PC, SRC_IMM, 5, 6, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("imm_sel3", PROBE, ARITH_S, SRC_IMM, SRC_PC, 5, 6, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("x0_reader", PROBE, ARITH_S, SRC_REG0, SRC_REG1, 0, 6, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("waw_x5", PROBE, ARITH_S, SRC_PC, SRC_IMM, 0, 5, 1, 2'b00, 0, 0, 2'b00, 2'b10);
    add("wb_x5", WB, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 1, 2'b11, 2'b00);
    add("raw_released", PROBE, ARITH_S, SRC_REG0, SRC_REG1, 5, 6, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    // structural hazards and store ordering
    add("div_busy", PROBE, DIV_S, SRC_REG0, SRC_REG1, 0, 6, 1, 2'b10, 0, 0, 2'b00, 2'b01);
    add("ls_busy", PROBE, LOADSTORE_S, SRC_REG0, SRC_IMM, 0, 6, 1, 2'b01, 0, 0, 2'b00, 2'b01);
    add("mul_units_busy", PROBE, MUL_S, SRC_REG0, SRC_REG1, 0, 6, 1, 2'b11, 0, 1, 2'b00, 2'b00);
    add("div_free", PROBE, DIV_S, SRC_REG0, SRC_REG1, 0, 6, 1, 2'b01, 0, 1, 2'b00, 2'b00);
    add("x7_dispatch", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 7, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("store_wait", PROBE, LOADSTORE_S, SRC_REG1, SRC_IMM, 0, 0, 0, 2'b00, 0, 0, 2'b00, 2'b00);
    add("load_pass", PROBE, LOADSTORE_S, SRC_REG0, SRC_IMM, 0, 6, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("wb_x7", WB, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 1, 1, 2'b11, 2'b00);
    add("store_empty", PROBE, LOADSTORE_S, SRC_REG1, SRC_IMM, 0, 0, 0, 2'b00, 0, 1, 2'b00, 2'b00);
    // fill the buffer, tags 2 3 0 1, then write back youngest first
    add("ord_dispatch0", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 8, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("ord_dispatch1", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 9, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("ord_dispatch2", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 10, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("ord_dispatch3", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 11, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("rob_full", PROBE, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 0, 2'b00, 2'b00);
    add("wb_tag1", WB, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 1, 0, 2'b10, 2'b00);
    add("wb_tag0", WB, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 0, 2'b10, 2'b00);
    add("wb_tag3", WB, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 3, 0, 2'b10, 2'b00);
    add("wb_tag2_head", WB, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 2, 0, 2'b11, 2'b00);
    add("full_released", PROBE, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 1, 2'b00, 2'b00);
    add("commit_drain", DRAIN, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 1, 2'b00, 2'b00);
    // exception on x12, tag 2
    add("exc_dispatch", DISP, ARITH_S, SRC_PC, SRC_IMM, 0, 12, 1, 2'b00, 0, 1, 2'b00, 2'b00);
    add("wb_exception", WBX, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 2, 1, 2'b10, 2'b00);
    add("exc_pending", PROBE, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 0, 2'b00, 2'b00);
    add("exc_handshake", ACK, ARITH_S, SRC_PC, SRC_IMM, 0, 0, 0, 2'b00, 0, 0, 2'b00, 2'b00);
    add("x12_reader", PROBE, ARITH_S, SRC_REG0, SRC_REG1, 12, 6, 1, 2'b00, 0, 1, 2'b00, 2'b00);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("reset", 32'd1, 32'(rob_empty));
    check("reset", 32'd0, {29'd0, commit_valid, exc_req, flush});
    $display("reset: %s", (errors == 0) ? "ok" : "failed");

    foreach (steps[i]) begin
      err_before = errors;
      cur_name = steps[i].name;
      step_no = i;
      run_step(steps[i]);
      if (errors != err_before) begin
        failed++;
      end
      $display("%s: %s", steps[i].name, (errors == err_before) ? "ok" : "failed");
    end

    $display("tests %0d, failed %0d, errors %0d", steps.size(), failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/ooo_pkg.sv
hazard/hazard_unit.sv
hazard/reg_scoreboard.sv
completion_buffer/completion_buffer.sv
design/exception_reporter.sv
design/ooo_issue_ctrl.sv
tb/ooo_issue_ctrl_assertions.sv
tb/tb_ooo_issue_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the issue-control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_ooo_issue_ctrl -f verilog.f

# the simulation may stop early on an assertion, the log still decides
./obj_dir/Vtb_ooo_issue_ctrl | tee sim.log || true

if grep -q "=== PASS ===" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
